//--- Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ex_pkg.sv
      - design/ex_result_if.sv
      - design/ex_alu.sv
      - design/ex_branch.sv
      - design/ex_multiplier.sv
      - design/ex_result_fifo.sv
      - design/ex_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/ex_stage_tb.sv

//--- design/ex_alu.sv
`include "ex_config.svh"

module ex_alu (
	input  logic [`XLEN-1:0]     opa,
	input  logic [`XLEN-1:0]     opb,
	input  ex_pkg::ex_alu_func_e func,
	output logic [`XLEN-1:0]     result
);
	import ex_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// shift amount from low five bits only
	assign shamt = opb[4:0];

	// compares for slt and sltu
	assign lt_signed   = $signed(opa) < $signed(opb);
	assign lt_unsigned = opa < opb;

	always_comb begin
		case (func)
			alu_add:  result = opa + opb;
			alu_sub:  result = opa - opb;
			alu_slt:  result = {{(`XLEN-1){1'b0}}, lt_signed};
			alu_sltu: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
			alu_and:  result = opa & opb;
			alu_or:   result = opa | opb;
			alu_xor:  result = opa ^ opb;
			alu_sll:  result = opa << shamt;
			alu_srl:  result = opa >> shamt;
			// arithmetic, keeps the sign
			alu_sra:  result = $signed(opa) >>> shamt;
			// multiplies go to the multipliers
			default:  result = '0;
		endcase
	end

endmodule

//--- design/ex_branch.sv
`include "ex_config.svh"

module ex_branch (
	input  logic [`XLEN-1:0] rs1,
	input  logic [`XLEN-1:0] rs2,
	input  logic [2:0]       funct3,
	input  logic [`XLEN-1:0] pc,
	input  logic [`XLEN-1:0] npc,
	input  logic [`XLEN-1:0] opa,
	input  logic [`XLEN-1:0] opb,
	output logic             cond,
	output logic [`XLEN-1:0] target,
	output logic [`XLEN-1:0] link
);

	logic eq;
	logic lt_signed;
	logic lt_unsigned;

	assign eq          = rs1 == rs2;
	assign lt_signed   = $signed(rs1) < $signed(rs2);
	assign lt_unsigned = rs1 < rs2;

	// funct3 picks the test
	always_comb begin
		case (funct3)
			3'b000:  cond = eq;
			3'b001:  cond = !eq;
			3'b100:  cond = lt_signed;
			3'b101:  cond = !lt_signed;
			3'b110:  cond = lt_unsigned;
			3'b111:  cond = !lt_unsigned;
			default: cond = 1'b0;
		endcase
	end

	// pc + imm for branches and jal, rs1 + imm for jalr
	assign target = {opa[`XLEN-1:1] + opb[`XLEN-1:1] + (`XLEN-1)'(opa[0] & opb[0]), 1'b0};

	// return address, pc + 4 when the issue side left npc empty
	assign link = (npc != '0) ? npc : pc + `XLEN'd4;

endmodule

//--- design/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath width
`define XLEN 32

// number of iterative multipliers, 1 to 4
`define MUL_NUM 2

// cycles from multiplier start to done
// has to divide XLEN evenly
`define MUL_CYCLES 4

// result queue entries, power of two
`define RES_DEPTH 8

`endif

//--- design/ex_multiplier.sv
`include "ex_config.svh"

module ex_multiplier (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 start,
	input  logic [`XLEN-1:0]     opa,
	input  logic [`XLEN-1:0]     opb,
	input  ex_pkg::ex_alu_func_e func,
	input  ex_pkg::ex_ctrl_t     ctrl_in,
	output logic                 busy,
	output logic                 done,
	output logic [`XLEN-1:0]     product,
	output ex_pkg::ex_ctrl_t     ctrl_out
);
	import ex_pkg::*;

	localparam int CHUNK = `XLEN / `MUL_CYCLES;
	localparam int CNT_W = $clog2(`MUL_CYCLES);

	logic               a_signed;
	logic               b_signed;
	logic [`XLEN:0]     a_ext;
	logic [`XLEN:0]     b_ext;
	logic [2*`XLEN-1:0] a_wide;
	logic [2*`XLEN-1:0] b_corr;
	logic [2*`XLEN-1:0] prod_init;
	logic [2*`XLEN-1:0] step_term;
	logic [2*`XLEN-1:0] prod_q;
	logic [2*`XLEN-1:0] mcand_q;
	logic [`XLEN-1:0]   mplier_q;
	logic [CNT_W-1:0]   count_q;
	logic               busy_q;
	ex_alu_func_e       func_q;
	ex_ctrl_t           ctrl_q;

	// mulh signs both, mulhsu only a
	assign a_signed = (func == alu_mulh) || (func == alu_mulhsu);
	assign b_signed = func == alu_mulh;
	assign a_ext    = {a_signed & opa[`XLEN-1], opa};
	assign b_ext    = {b_signed & opb[`XLEN-1], opb};
	assign a_wide   = {{(`XLEN-1){a_ext[`XLEN]}}, a_ext};

	// negative b weighs -2^XLEN at its top bit
	assign b_corr    = b_ext[`XLEN] ? (a_wide << `XLEN) : '0;
	// first chunk folds in at the start edge
	assign prod_init = a_wide * (2*`XLEN)'(b_ext[CHUNK-1:0]) - b_corr;
	assign step_term = mcand_q * (2*`XLEN)'(mplier_q[CHUNK-1:0]);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy_q  <= 1'b0;
			count_q <= '0;
		end else if (start) begin
			busy_q  <= 1'b1;
			count_q <= CNT_W'(`MUL_CYCLES - 1);
		end else if (busy_q) begin
			// done cycle frees the unit
			if (count_q == '0)
				busy_q <= 1'b0;
			else
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			prod_q   <= prod_init;
			mcand_q  <= a_wide << CHUNK;
			mplier_q <= b_ext[`XLEN-1:0] >> CHUNK;
			func_q   <= func;
			ctrl_q   <= ctrl_in;
		end else if (busy_q && count_q != '0) begin
			prod_q   <= prod_q + step_term;
			mcand_q  <= mcand_q << CHUNK;
			mplier_q <= mplier_q >> CHUNK;
		end
	end

	assign busy     = busy_q;
	assign done     = busy_q && (count_q == '0);
	// low word for mul, high word for the rest
	assign product  = (func_q == alu_mul) ? prod_q[`XLEN-1:0] : prod_q[2*`XLEN-1:`XLEN];
	assign ctrl_out = ctrl_q;

	// allocator upstream only picks idle units
	a_no_start_busy: assert property (@(posedge clock) disable iff (!arst_n)
		start |-> !busy_q)
		else $error("multiplier started while busy");

endmodule

//--- design/ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

	////////////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////////////

	// which unit group takes the instruction
	typedef enum logic [1:0] {
		chan_none, chan_alu, chan_br, chan_mult
	} ex_channel_e;

	typedef enum logic [1:0] {
		opa_rs1, opa_npc, opa_pc, opa_zero
	} ex_opa_sel_e;

	typedef enum logic [2:0] {
		opb_rs2, opb_i_imm, opb_s_imm, opb_b_imm, opb_u_imm, opb_j_imm
	} ex_opb_sel_e;

	// multiply codes sit at the top, the ALU never sees them
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra, alu_mul, alu_mulh, alu_mulhsu, alu_mulhu
	} ex_alu_func_e;

	////////////////////////////////////////////////////////////////////////////
	// packets
	////////////////////////////////////////////////////////////////////////////

	// fields that ride along untouched
	typedef struct packed {
		logic [3:0]       tag;
		logic [`XLEN-1:0] npc;
		logic [`XLEN-1:0] rs2_value;
		logic [4:0]       dest_reg_idx;
		logic             rd_mem;
		logic             wr_mem;
		logic [2:0]       mem_size;
		logic             halt;
		logic             illegal;
		logic             valid;
	} ex_ctrl_t;

	typedef struct packed {
		ex_ctrl_t         ctrl;
		ex_channel_e      channel;
		logic [`XLEN-1:0] pc;
		logic [31:0]      inst;
		logic [`XLEN-1:0] rs1_value;
		ex_opa_sel_e      opa_select;
		ex_opb_sel_e      opb_select;
		ex_alu_func_e     alu_func;
		logic             cond_branch;
		logic             uncond_branch;
	} ex_issue_t;

	typedef struct packed {
		ex_ctrl_t         ctrl;
		logic [`XLEN-1:0] result;
		logic             take_branch;
		logic             is_zeroreg;
	} ex_packet_t;

	// immediate decode, sign extended
	function automatic logic [`XLEN-1:0] imm_i(input logic [31:0] inst);
		return {{(`XLEN-12){inst[31]}}, inst[31:20]};
	endfunction

	function automatic logic [`XLEN-1:0] imm_s(input logic [31:0] inst);
		return {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	endfunction

	function automatic logic [`XLEN-1:0] imm_b(input logic [31:0] inst);
		return {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	endfunction

	// upper 20 bits, low 12 zero
	function automatic logic [`XLEN-1:0] imm_u(input logic [31:0] inst);
		return {inst[31:12], 12'h000};
	endfunction

	function automatic logic [`XLEN-1:0] imm_j(input logic [31:0] inst);
		return {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	endfunction

endpackage

//--- design/ex_result_fifo.sv
`include "ex_config.svh"

module ex_result_fifo (
	input  logic                              clock,
	input  logic                              arst_n,
	ex_result_if.queue                        single_res,
	ex_result_if.queue                        mult_res,
	output ex_pkg::ex_packet_t                ex_packet_out,
	output logic                              out_valid,
	output logic [$clog2(`RES_DEPTH):0]       free_count
);
	import ex_pkg::*;

	localparam int PTR_W = $clog2(`RES_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	ex_packet_t       mem [`RES_DEPTH];
	ex_packet_t       pkt_single;
	ex_packet_t       pkt_mult;
	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [PTR_W-1:0] mult_ptr;
	logic [CNT_W-1:0] count_q;
	logic [1:0]       n_wr;
	logic             pop;

	// pack both sources
	always_comb begin
		pkt_single.ctrl        = single_res.ctrl;
		pkt_single.result      = single_res.result;
		pkt_single.take_branch = single_res.take_branch;
		pkt_single.is_zeroreg  = single_res.ctrl.dest_reg_idx == 5'd0;
		pkt_mult.ctrl          = mult_res.ctrl;
		pkt_mult.result        = mult_res.result;
		pkt_mult.take_branch   = mult_res.take_branch;
		pkt_mult.is_zeroreg    = mult_res.ctrl.dest_reg_idx == 5'd0;
	end

	assign n_wr = {1'b0, single_res.done} + {1'b0, mult_res.done};
	// head leaves every cycle, nothing below stalls
	assign pop  = count_q != '0;
	// single result goes first on a double write
	assign mult_ptr = single_res.done ? tail_q + 1'b1 : tail_q;

	always_ff @(posedge clock) begin
		if (single_res.done)
			mem[tail_q] <= pkt_single;
		if (mult_res.done)
			mem[mult_ptr] <= pkt_mult;
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			head_q  <= head_q + PTR_W'(pop);
			tail_q  <= tail_q + PTR_W'(n_wr);
			count_q <= count_q + CNT_W'(n_wr) - CNT_W'(pop);
		end
	end

	assign ex_packet_out = mem[head_q];
	assign out_valid     = pop;
	assign free_count    = CNT_W'(`RES_DEPTH) - count_q;

	// the two-free-entry issue rule keeps this true
	a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
		int'(count_q) + int'(n_wr) - int'(pop) <= `RES_DEPTH)
		else $error("result queue overflow");

endmodule

//--- design/ex_result_if.sv
`include "ex_config.svh"

// one finished result per done pulse
interface ex_result_if;
	import ex_pkg::*;

	logic             done;
	ex_ctrl_t         ctrl;
	logic [`XLEN-1:0] result;
	logic             take_branch;

	// merge logic side
	modport unit (
		output done,
		output ctrl,
		output result,
		output take_branch
	);

	// queue side, written at the edge that ends the done cycle
	modport queue (
		input done,
		input ctrl,
		input result,
		input take_branch
	);

endinterface

//--- design/ex_stage.sv
`include "ex_config.svh"

module ex_stage (
	input  logic               clock,
	input  logic               arst_n,
	input  ex_pkg::ex_issue_t  issue_in,
	output logic               issue_ready,
	output ex_pkg::ex_packet_t ex_packet_out,
	output logic               out_valid
);
	import ex_pkg::*;

	logic [`XLEN-1:0]                 opa_mux;
	logic [`XLEN-1:0]                 opb_mux;
	logic [`XLEN-1:0]                 alu_result;
	logic                             br_cond;
	logic [`XLEN-1:0]                 br_target;
	logic [`XLEN-1:0]                 br_link;
	logic                             accept;
	logic                             alu_go;
	logic                             br_go;
	logic                             mul_go;
	logic [`MUL_NUM-1:0]              mul_idle;
	logic [`MUL_NUM-1:0]              mul_grant;
	logic [`MUL_NUM-1:0]              mul_start;
	logic [`MUL_NUM-1:0]              mul_busy;
	logic [`MUL_NUM-1:0]              mul_done;
	logic [`MUL_NUM-1:0][`XLEN-1:0]   mul_product;
	ex_ctrl_t [`MUL_NUM-1:0]          mul_ctrl;
	logic [$clog2(`RES_DEPTH):0]      free_count;

	ex_result_if single_res ();
	ex_result_if mult_res ();

	////////////////////////////////////////////////////////////////////////////
	// operand select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (issue_in.opa_select)
			opa_rs1: opa_mux = issue_in.rs1_value;
			opa_npc: opa_mux = issue_in.ctrl.npc;
			opa_pc:  opa_mux = issue_in.pc;
			default: opa_mux = '0;
		endcase
	end

	always_comb begin
		case (issue_in.opb_select)
			opb_rs2:   opb_mux = issue_in.ctrl.rs2_value;
			opb_i_imm: opb_mux = imm_i(issue_in.inst);
			opb_s_imm: opb_mux = imm_s(issue_in.inst);
			opb_b_imm: opb_mux = imm_b(issue_in.inst);
			opb_u_imm: opb_mux = imm_u(issue_in.inst);
			opb_j_imm: opb_mux = imm_j(issue_in.inst);
			// codes 6 and 7 unused
			default:   opb_mux = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// issue and dispatch
	////////////////////////////////////////////////////////////////////////////

	// lowest idle multiplier wins
	assign mul_idle  = ~mul_busy;
	assign mul_grant = mul_idle & (~mul_idle + 1'b1);

	// room for one result from each side, plus a unit for multiplies
	assign issue_ready = (free_count >= 2) &&
		((issue_in.channel != chan_mult) || (|mul_idle));

	assign accept    = issue_in.ctrl.valid && (issue_in.channel != chan_none) && issue_ready;
	assign alu_go    = accept && (issue_in.channel == chan_alu);
	assign br_go     = accept && (issue_in.channel == chan_br);
	assign mul_go    = accept && (issue_in.channel == chan_mult);
	assign mul_start = mul_go ? mul_grant : '0;

	ex_alu alu0 (
		.opa    (opa_mux),
		.opb    (opb_mux),
		.func   (issue_in.alu_func),
		.result (alu_result)
	);

	ex_branch br0 (
		.rs1    (issue_in.rs1_value),
		.rs2    (issue_in.ctrl.rs2_value),
		.funct3 (issue_in.inst[14:12]),
		.pc     (issue_in.pc),
		.npc    (issue_in.ctrl.npc),
		.opa    (opa_mux),
		.opb    (opb_mux),
		.cond   (br_cond),
		.target (br_target),
		.link   (br_link)
	);

	for (genvar i = 0; i < `MUL_NUM; i++) begin : g_mul
		ex_multiplier mul (
			.clock    (clock),
			.arst_n   (arst_n),
			.start    (mul_start[i]),
			.opa      (opa_mux),
			.opb      (opb_mux),
			.func     (issue_in.alu_func),
			.ctrl_in  (issue_in.ctrl),
			.busy     (mul_busy[i]),
			.done     (mul_done[i]),
			.product  (mul_product[i]),
			.ctrl_out (mul_ctrl[i])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// result merge
	////////////////////////////////////////////////////////////////////////////

	// single cycle side, written at the issue edge
	assign single_res.done        = alu_go || br_go;
	assign single_res.ctrl        = issue_in.ctrl;
	// jumps return the link, branches the target
	assign single_res.result      = br_go ? (issue_in.uncond_branch ? br_link : br_target)
		: alu_result;
	assign single_res.take_branch = br_go &&
		(issue_in.uncond_branch || (issue_in.cond_branch && br_cond));

	// dones never overlap, equal latency and one start per edge
	always_comb begin
		mult_res.done        = |mul_done;
		mult_res.ctrl        = '0;
		mult_res.result      = '0;
		mult_res.take_branch = 1'b0;
		for (int i = 0; i < `MUL_NUM; i++) begin
			if (mul_done[i]) begin
				mult_res.ctrl   = mul_ctrl[i];
				mult_res.result = mul_product[i];
			end
		end
	end

	ex_result_fifo fifo0 (
		.clock         (clock),
		.arst_n        (arst_n),
		.single_res    (single_res),
		.mult_res      (mult_res),
		.ex_packet_out (ex_packet_out),
		.out_valid     (out_valid),
		.free_count    (free_count)
	);

	a_one_mul_done: assert property (@(posedge clock) disable iff (!arst_n)
		$onehot0(mul_done))
		else $error("two multipliers done in one cycle");

	// an accepted instruction reaches exactly one unit
	a_one_target: assert property (@(posedge clock) disable iff (!arst_n)
		accept |-> $onehot({single_res.done, mul_start}))
		else $error("accepted instruction not sent to exactly one unit");

endmodule

//--- ex_stage.f
+incdir+design
design/ex_pkg.sv
design/ex_result_if.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_multiplier.sv
design/ex_result_fifo.sv
design/ex_stage.sv
testbench/ex_stage_tb.sv

//--- testbench/ex_stage_tb.sv
`include "ex_config.svh"

module ex_stage_tb;
	import ex_pkg::*;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 10;
	localparam int DRIVE_DELAY  = 1;
	localparam int RESET_CYCLES = 10;
	localparam int N_INSTR      = 120;
	// reset, worst case three cycles per instruction, drain margin
	localparam int MAX_CYCLES   = RESET_CYCLES + 3 * N_INSTR + 30;

	logic       clock = 1'b0;
	logic       arst_n;
	ex_issue_t  issue_in;
	logic       issue_ready;
	ex_packet_t ex_packet_out;
	logic       out_valid;

	integer     seed = 14;
	int         value_errs = 0;
	int         flow_errs = 0;
	int         cycle_count = 0;

	// reference model state, one slot per tag
	ex_packet_t expected [16];
	logic       pending [16];
	int         mul_left [`MUL_NUM];
	int         mul_used;
	int         q_count;
	int         n_acc;
	int         n_out;

	// dut outputs taken mid cycle
	logic       ready_s = 1'b0;
	logic       ov_s = 1'b0;
	ex_packet_t pkt_s;

	logic [2:0] f3_tab [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	always #(CLK_PERIOD / 2) clock = ~clock;

	ex_stage dut0 (
		.clock         (clock),
		.arst_n        (arst_n),
		.issue_in      (issue_in),
		.issue_ready   (issue_ready),
		.ex_packet_out (ex_packet_out),
		.out_valid     (out_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	// corner operands for the multiplies and compares
	function automatic logic [`XLEN-1:0] edge_value(input logic [`XLEN-1:0] r);
		case (r[2:0])
			3'd0:    return '0;
			3'd1:    return `XLEN'd1;
			3'd2:    return '1;
			3'd3:    return {1'b1, {(`XLEN-1){1'b0}}};
			3'd4:    return {1'b0, {(`XLEN-1){1'b1}}};
			default: return r;
		endcase
	endfunction

	// immediates straight from the RISC-V encodings
	function automatic logic [`XLEN-1:0] decode_imm(input ex_opb_sel_e sel,
		input logic [31:0] inst);
		logic signed [11:0] i12;
		logic signed [12:0] b13;
		logic signed [20:0] j21;
		case (sel)
			opb_i_imm: begin
				i12 = inst[31:20];
				return `XLEN'(i12);
			end
			opb_s_imm: begin
				i12 = {inst[31:25], inst[11:7]};
				return `XLEN'(i12);
			end
			opb_b_imm: begin
				b13 = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
				return `XLEN'(b13);
			end
			opb_u_imm: return `XLEN'({inst[31:12], 12'h000});
			opb_j_imm: begin
				j21 = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
				return `XLEN'(j21);
			end
			default:   return '0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] operand_a(input ex_issue_t ins);
		case (ins.opa_select)
			opa_rs1: return ins.rs1_value;
			opa_npc: return ins.ctrl.npc;
			opa_pc:  return ins.pc;
			default: return '0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] operand_b(input ex_issue_t ins);
		if (ins.opb_select == opb_rs2)
			return ins.ctrl.rs2_value;
		return decode_imm(ins.opb_select, ins.inst);
	endfunction

	function automatic logic [`XLEN-1:0] alu_model(input ex_alu_func_e f,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		logic [`XLEN-1:0] fill;
		// sign fill for sra, top sh bits
		fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> b[4:0]) : '0;
		case (f)
			alu_add:  return a + b;
			alu_sub:  return a - b;
			alu_slt:  return ($signed(a) < $signed(b)) ? `XLEN'd1 : `XLEN'd0;
			alu_sltu: return (a < b) ? `XLEN'd1 : `XLEN'd0;
			alu_and:  return a & b;
			alu_or:   return a | b;
			alu_xor:  return a ^ b;
			alu_sll:  return a << b[4:0];
			alu_srl:  return a >> b[4:0];
			alu_sra:  return (a >> b[4:0]) | fill;
			default:  return '0;
		endcase
	endfunction

	// full product on 66 bits, signs by function
	function automatic logic [`XLEN-1:0] mul_model(input ex_alu_func_e f,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		logic                      sa;
		logic                      sb;
		logic signed [2*`XLEN+1:0] wa;
		logic signed [2*`XLEN+1:0] wb;
		logic signed [2*`XLEN+1:0] full;
		sa   = ((f == alu_mulh) || (f == alu_mulhsu)) && a[`XLEN-1];
		sb   = (f == alu_mulh) && b[`XLEN-1];
		wa   = {{(`XLEN+2){sa}}, a};
		wb   = {{(`XLEN+2){sb}}, b};
		full = wa * wb;
		if (f == alu_mul)
			return full[`XLEN-1:0];
		return full[2*`XLEN-1:`XLEN];
	endfunction

	function automatic logic branch_holds(input logic [2:0] f3,
		input logic [`XLEN-1:0] x, input logic [`XLEN-1:0] y);
		case (f3)
			3'd0:    return x == y;
			3'd1:    return x != y;
			3'd4:    return $signed(x) < $signed(y);
			3'd5:    return $signed(x) >= $signed(y);
			3'd6:    return x < y;
			3'd7:    return x >= y;
			default: return 1'b0;
		endcase
	endfunction

	function automatic ex_packet_t expect_packet(input ex_issue_t ins);
		ex_packet_t       p;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		a             = operand_a(ins);
		b             = operand_b(ins);
		p.ctrl        = ins.ctrl;
		p.is_zeroreg  = ins.ctrl.dest_reg_idx == 5'd0;
		p.take_branch = 1'b0;
		case (ins.channel)
			chan_br: begin
				p.take_branch = ins.uncond_branch || (ins.cond_branch &&
					branch_holds(ins.inst[14:12], ins.rs1_value, ins.ctrl.rs2_value));
				// jumps hand back the return address
				p.result = ins.uncond_branch ? ins.ctrl.npc : ((a + b) & ~`XLEN'd1);
			end
			chan_mult: p.result = mul_model(ins.alu_func, a, b);
			default:   p.result = alu_model(ins.alu_func, a, b);
		endcase
		return p;
	endfunction

	always @(negedge clock) begin
		ready_s = issue_ready;
		ov_s    = out_valid;
		pkt_s   = ex_packet_out;
	end

	// queue fill, multiplier occupancy and pending tags, edge by edge
	always @(posedge clock or negedge arst_n) begin
		int writes;
		int used;
		int left_n [`MUL_NUM];
		logic slot_taken;
		if (!arst_n) begin
			for (int i = 0; i < `MUL_NUM; i++)
				mul_left[i] <= 0;
			for (int t = 0; t < 16; t++)
				pending[t] <= 1'b0;
			mul_used <= 0;
			q_count  <= 0;
			n_acc    <= 0;
			n_out    <= 0;
		end else begin
			writes     = 0;
			used       = 0;
			slot_taken = 1'b0;
			// a unit with one cycle left writes at this edge
			for (int i = 0; i < `MUL_NUM; i++) begin
				left_n[i] = mul_left[i];
				if (left_n[i] == 1)
					writes++;
				if (left_n[i] > 0)
					left_n[i]--;
			end
			if (ov_s) begin
				pending[pkt_s.ctrl.tag] <= 1'b0;
				n_out <= n_out + 1;
			end
			if (ready_s && issue_in.ctrl.valid && issue_in.channel != chan_none) begin
				if (pending[issue_in.ctrl.tag]) begin
					flow_errs++;
					$display("tag %0d was issued again while still in flight",
						issue_in.ctrl.tag);
				end
				expected[issue_in.ctrl.tag] <= expect_packet(issue_in);
				pending[issue_in.ctrl.tag]  <= 1'b1;
				n_acc <= n_acc + 1;
				if (issue_in.channel == chan_mult) begin
					for (int i = 0; i < `MUL_NUM; i++) begin
						if (!slot_taken && left_n[i] == 0) begin
							left_n[i]  = `MUL_CYCLES;
							slot_taken = 1'b1;
						end
					end
				end else begin
					writes++;
				end
			end
			for (int i = 0; i < `MUL_NUM; i++) begin
				mul_left[i] <= left_n[i];
				if (left_n[i] > 0)
					used++;
			end
			mul_used <= used;
			q_count  <= q_count + writes - ((q_count > 0) ? 1 : 0);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_tag_pending: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid |-> pending[ex_packet_out.ctrl.tag])
		else begin
			flow_errs++;
			$display("FAIL %0t: tag %0d left the stage but was not in flight",
				$time, pkt_s.ctrl.tag);
		end

	a_result: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid |-> ex_packet_out.result == expected[ex_packet_out.ctrl.tag].result)
		else begin
			value_errs++;
			$display("FAIL %0t: tag %0d result %h, expected %h", $time,
				pkt_s.ctrl.tag, pkt_s.result, expected[pkt_s.ctrl.tag].result);
		end

	a_take_branch: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid |->
		ex_packet_out.take_branch == expected[ex_packet_out.ctrl.tag].take_branch)
		else begin
			value_errs++;
			$display("FAIL %0t: tag %0d take_branch %b, expected %b", $time,
				pkt_s.ctrl.tag, pkt_s.take_branch, expected[pkt_s.ctrl.tag].take_branch);
		end

	a_ctrl: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid |-> ex_packet_out.ctrl == expected[ex_packet_out.ctrl.tag].ctrl)
		else begin
			value_errs++;
			$display("FAIL %0t: tag %0d pass-through fields changed", $time,
				pkt_s.ctrl.tag);
		end

	a_zeroreg: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid |->
		ex_packet_out.is_zeroreg == expected[ex_packet_out.ctrl.tag].is_zeroreg)
		else begin
			value_errs++;
			$display("FAIL %0t: tag %0d is_zeroreg %b, expected %b", $time,
				pkt_s.ctrl.tag, pkt_s.is_zeroreg, expected[pkt_s.ctrl.tag].is_zeroreg);
		end

	// out_valid follows the modelled queue fill
	a_out_valid: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid == (q_count != 0))
		else begin
			flow_errs++;
			$display("FAIL %0t: out_valid %b with %0d results queued", $time,
				ov_s, q_count);
		end

	// stall only on a full set of multipliers or a nearly full queue
	a_issue_ready: assert property (@(posedge clock) disable iff (!arst_n)
		issue_ready == ((`RES_DEPTH - q_count >= 2) &&
		(issue_in.channel != chan_mult || mul_used < `MUL_NUM)))
		else begin
			flow_errs++;
			$display("FAIL %0t: issue_ready %b, %0d multipliers busy, %0d queued",
				$time, ready_s, mul_used, q_count);
		end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic make_instr(input int n, output ex_issue_t ins);
		int kind;
		int pick;
		ins                   = '0;
		ins.ctrl.tag          = 4'(n);
		ins.ctrl.valid        = 1'b1;
		ins.ctrl.dest_reg_idx = (($random(seed) & 7) == 0) ? 5'd0 : 5'($random(seed));
		ins.ctrl.rd_mem       = 1'($random(seed));
		ins.ctrl.wr_mem       = 1'($random(seed));
		ins.ctrl.mem_size     = 3'($random(seed));
		ins.ctrl.halt         = 1'($random(seed));
		ins.ctrl.illegal      = 1'($random(seed));
		ins.pc                = `XLEN'($random(seed)) & ~`XLEN'd3;
		ins.ctrl.npc          = ins.pc + `XLEN'd4;
		ins.inst              = 32'($random(seed));
		ins.rs1_value         = edge_value(`XLEN'($random(seed)));
		ins.ctrl.rs2_value    = edge_value(`XLEN'($random(seed)));
		// directed sweeps first, multiply burst at 40, random around it
		if (n < 20)
			kind = 1;
		else if (n < 32)
			kind = 2;
		else if (n >= 40 && n < 48)
			kind = 3;
		else
			kind = 1 + int'($unsigned($random(seed)) % 3);
		case (kind)
			1: begin
				pick           = (n < 20) ? n : int'($unsigned($random(seed)) % 60);
				ins.channel    = chan_alu;
				ins.opa_select = ex_opa_sel_e'(2'($random(seed)));
				ins.opb_select = ex_opb_sel_e'(3'(pick % 6));
				ins.alu_func   = ex_alu_func_e'(4'(pick % 10));
			end
			2: begin
				pick        = (n < 32) ? n - 20 : int'($unsigned($random(seed)) % 12);
				ins.channel = chan_br;
				if (pick >= 10) begin
					// jal off pc, jalr off rs1
					ins.uncond_branch = 1'b1;
					ins.opa_select    = (pick == 10) ? opa_pc : opa_rs1;
					ins.opb_select    = (pick == 10) ? opb_j_imm : opb_i_imm;
				end else begin
					ins.cond_branch   = 1'b1;
					ins.opa_select    = opa_pc;
					ins.opb_select    = opb_b_imm;
					ins.inst[14:12]   = f3_tab[pick % 6];
					if (1'($random(seed)))
						ins.ctrl.rs2_value = ins.rs1_value;
				end
			end
			default: begin
				ins.channel    = chan_mult;
				ins.opa_select = opa_rs1;
				ins.opb_select = opb_rs2;
				ins.alu_func   = ex_alu_func_e'(4'(int'(alu_mul) + n % 4));
			end
		endcase
	endtask

	initial begin
		ex_issue_t ins;
		issue_in = '0;
		arst_n   = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#(DRIVE_DELAY);
		arst_n = 1'b1;
		a_reset_state: assert (!out_valid && issue_ready)
			else begin
				flow_errs++;
				$display("stage not idle after reset: out_valid %b issue_ready %b",
					out_valid, issue_ready);
			end
		for (int n = 0; n < N_INSTR; n++) begin
			// an idle cycle now and then, never inside the burst
			if ((n < 40 || n >= 48) && ($random(seed) & 7) == 0) begin
				issue_in.ctrl.valid = 1'b0;
				@(posedge clock);
				#(DRIVE_DELAY);
			end
			make_instr(n, ins);
			issue_in = ins;
			// source holds until the stage takes it
			@(posedge clock);
			while (!ready_s)
				@(posedge clock);
			#(DRIVE_DELAY);
		end
		issue_in = '0;
		while (n_out < N_INSTR)
			@(posedge clock);
		repeat (2) @(posedge clock);
		a_all_retired: assert (n_out == n_acc)
			else begin
				flow_errs++;
				$display("%0d results left the stage for %0d accepted", n_out, n_acc);
			end
		for (int t = 0; t < 16; t++) begin
			if (pending[t]) begin
				flow_errs++;
				$display("tag %0d never left the stage", t);
			end
		end
		$display("errors: %0d value, %0d flow", value_errs, flow_errs);
		if (value_errs + flow_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// hard stop
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("errors: %0d value, %0d flow", value_errs, flow_errs);
			$display("TB FAILED");
			$finish;
		end
	end

endmodule
